/* msx_ctrl_pkg.sv */
/*
 * MSX controller adapter, host side definitions
 * Joystick vector layout, mouse report field sizes and the
 * credit depth shared by the input router and the port engines
 */
package msx_ctrl_pkg;

	// Number of MSX general purpose ports
	localparam int NUM_PORTS = 2;
	localparam int PORT_BITS = $clog2(NUM_PORTS);

	// Host joystick vector, active high
	localparam int JOY_BITS = 6;
	localparam int JOY_UP = 0;
	localparam int JOY_DOWN = 1;
	localparam int JOY_LEFT = 2;
	localparam int JOY_RIGHT = 3;
	localparam int JOY_TRIG_A = 4;
	localparam int JOY_TRIG_B = 5;

	// Mouse report fields, movement is two's complement
	localparam int MOVE_BITS = 9;
	localparam int BTN_BITS = 2;

	// Reports held per engine, also the starting credit of a port
	localparam int REPORT_DEPTH = 2;
	localparam int CREDIT_BITS = 2;
	localparam int QUEUE_PTR_BITS = $clog2(REPORT_DEPTH);

endpackage

/* msx_port_pkg.sv */
/*
 * MSX general purpose port definitions
 * Line positions in the 6-bit pin vector and the mouse
 * read protocol constants
 */
package msx_port_pkg;

	localparam int PIN_BITS = 6;

	// Directions run opposite to the host joystick order
	localparam int PIN_RIGHT = 0;
	localparam int PIN_LEFT = 1;
	localparam int PIN_DOWN = 2;
	localparam int PIN_UP = 3;
	localparam int PIN_TRIG_A = 4;
	localparam int PIN_TRIG_B = 5;

	// Mouse data goes out one nibble per strobe toggle
	localparam int NIBBLE_BITS = 4;

	// Idle cycles before a mouse read restarts at the first nibble
	localparam int MOUSE_TIMEOUT = 100000;
	localparam int TIMEOUT_BITS = $clog2(MOUSE_TIMEOUT + 1);

endpackage

/* host_input_router.sv */
/*
 * Host input router
 * Applies the joystick swap and hands mouse reports to the selected
 * MSX port. Each port has a credit counter; while it is empty the
 * movement is summed into a saturating pending report.
 */
`timescale 1ns/1ps

module host_input_router (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic [msx_ctrl_pkg::JOY_BITS-1:0]   joy0_i,
	input  logic [msx_ctrl_pkg::JOY_BITS-1:0]   joy1_i,
	input  logic                                swap_i,
	input  logic [msx_ctrl_pkg::MOVE_BITS-1:0]  mouse_dx_i,
	input  logic [msx_ctrl_pkg::MOVE_BITS-1:0]  mouse_dy_i,
	input  logic [msx_ctrl_pkg::BTN_BITS-1:0]   mouse_btn_i,
	input  logic                                mouse_strobe_i,
	input  logic [msx_ctrl_pkg::PORT_BITS-1:0]  mouse_port_i,
	input  logic [msx_ctrl_pkg::NUM_PORTS-1:0]  credit_ret_i,
	output logic [msx_ctrl_pkg::JOY_BITS-1:0]   joy_o [msx_ctrl_pkg::NUM_PORTS],
	output logic [msx_ctrl_pkg::NUM_PORTS-1:0]  rpt_valid_o,
	output logic [msx_ctrl_pkg::MOVE_BITS-1:0]  rpt_dx_o [msx_ctrl_pkg::NUM_PORTS],
	output logic [msx_ctrl_pkg::MOVE_BITS-1:0]  rpt_dy_o [msx_ctrl_pkg::NUM_PORTS],
	output logic [msx_ctrl_pkg::BTN_BITS-1:0]   btn_o
);
	import msx_ctrl_pkg::*;

	// Signed add clamped to the movement field range
	function automatic logic [MOVE_BITS-1:0] sat_add(
		input logic [MOVE_BITS-1:0] a,
		input logic [MOVE_BITS-1:0] b
	);
		logic [MOVE_BITS:0] sum;
		sum = {a[MOVE_BITS-1], a} + {b[MOVE_BITS-1], b};
		if (sum[MOVE_BITS] != sum[MOVE_BITS-1]) begin
			if (sum[MOVE_BITS])
				return {1'b1, {(MOVE_BITS - 1){1'b0}}};
			return {1'b0, {(MOVE_BITS - 1){1'b1}}};
		end
		return sum[MOVE_BITS-1:0];
	endfunction

	// ==========================================================
	// Joysticks and buttons
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_o[0] <= '0;
			joy_o[1] <= '0;
			btn_o <= '0;
		end else begin
			joy_o[0] <= swap_i ? joy1_i : joy0_i;
			joy_o[1] <= swap_i ? joy0_i : joy1_i;
			btn_o <= mouse_btn_i;
		end
	end

	// ==========================================================
	// Mouse reports under credit control
	// ==========================================================
	genvar p;
	generate
		for (p = 0; p < NUM_PORTS; p++) begin : g_port
			logic [CREDIT_BITS-1:0] credit;
			logic                   pend_valid;
			logic [MOVE_BITS-1:0]   pend_dx;
			logic [MOVE_BITS-1:0]   pend_dy;
			logic [MOVE_BITS-1:0]   sum_dx;
			logic [MOVE_BITS-1:0]   sum_dy;
			logic [MOVE_BITS-1:0]   out_dx;
			logic [MOVE_BITS-1:0]   out_dy;
			logic                   valid_q;
			logic                   take;
			logic                   send;

			assign take = mouse_strobe_i && (mouse_port_i == PORT_BITS'(p));
			// A fresh report is folded into whatever is still pending
			assign sum_dx = sat_add(pend_valid ? pend_dx : '0, take ? mouse_dx_i : '0);
			assign sum_dy = sat_add(pend_valid ? pend_dy : '0, take ? mouse_dy_i : '0);
			assign send = (credit != '0) && (take || pend_valid);

			always_ff @(posedge clk_sys) begin
				if (reset) begin
					credit <= CREDIT_BITS'(REPORT_DEPTH);
					pend_valid <= 1'b0;
					valid_q <= 1'b0;
				end else begin
					credit <= credit + CREDIT_BITS'(credit_ret_i[p]) - CREDIT_BITS'(send);
					valid_q <= send;
					if (send)
						pend_valid <= 1'b0;
					else if (take)
						pend_valid <= 1'b1;
				end
			end

			always_ff @(posedge clk_sys) begin
				if (send) begin
					out_dx <= sum_dx;
					out_dy <= sum_dy;
				end else if (take) begin
					pend_dx <= sum_dx;
					pend_dy <= sum_dy;
				end
			end

			assign rpt_valid_o[p] = valid_q;
			assign rpt_dx_o[p] = out_dx;
			assign rpt_dy_o[p] = out_dy;
		end
	endgenerate

endmodule

/* msx_port_engine.sv */
/*
 * MSX port engine
 * Holds mouse reports for one port and tracks whether the port
 * is in mouse mode. Each strobe toggle presents the next nibble of
 * the head report; the fourth nibble retires it and returns a credit.
 */
`timescale 1ns/1ps

module msx_port_engine (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic [msx_ctrl_pkg::JOY_BITS-1:0]    joy_i,
	input  logic                                 strobe_i,
	input  logic                                 rpt_valid_i,
	input  logic [msx_ctrl_pkg::MOVE_BITS-1:0]   rpt_dx_i,
	input  logic [msx_ctrl_pkg::MOVE_BITS-1:0]   rpt_dy_i,
	output logic                                 credit_ret_o,
	output logic                                 mouse_mode_o,
	output logic [msx_port_pkg::NIBBLE_BITS-1:0] nibble_o
);
	import msx_ctrl_pkg::*;
	import msx_port_pkg::*;

	// Report queue
	logic [MOVE_BITS-1:0]      q_dx [REPORT_DEPTH];
	logic [MOVE_BITS-1:0]      q_dy [REPORT_DEPTH];
	logic [QUEUE_PTR_BITS-1:0] wr_ptr;
	logic [QUEUE_PTR_BITS-1:0] rd_ptr;
	logic [CREDIT_BITS-1:0]    q_count;
	logic                      q_empty;
	logic                      pop;
	logic                      flush;

	// Read sequencer
	logic                      strobe_d;
	logic                      toggle;
	logic [1:0]                seq;
	logic [TIMEOUT_BITS-1:0]   timer;
	logic [MOVE_BITS-1:0]      head_dx;
	logic [MOVE_BITS-1:0]      head_dy;
	logic [MOVE_BITS-1:0]      neg_dx;
	logic [MOVE_BITS-1:0]      lat_dx;
	logic [MOVE_BITS-1:0]      lat_dy;
	logic                      lat_valid;
	logic                      read_done;

	assign q_empty = (q_count == '0);
	assign head_dx = q_empty ? '0 : q_dx[rd_ptr];
	assign head_dy = q_empty ? '0 : q_dy[rd_ptr];
	// MSX mice report X with the opposite sign
	assign neg_dx = -head_dx;

	assign toggle = mouse_mode_o && (strobe_i != strobe_d);
	assign read_done = toggle && (seq == 2'd3) && lat_valid;
	// Out of mouse mode the queue drains one entry per cycle
	assign flush = !mouse_mode_o && !q_empty;
	assign pop = read_done || flush;

	// ==========================================================
	// Queue and mode
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (rpt_valid_i) begin
			q_dx[wr_ptr] <= rpt_dx_i;
			q_dy[wr_ptr] <= rpt_dy_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
			credit_ret_o <= 1'b0;
			mouse_mode_o <= 1'b0;
		end else begin
			if (rpt_valid_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			q_count <= q_count + CREDIT_BITS'(rpt_valid_i) - CREDIT_BITS'(pop);
			credit_ret_o <= pop;

			// A new report wins over a held joystick bit
			if (rpt_valid_i)
				mouse_mode_o <= 1'b1;
			else if (|joy_i)
				mouse_mode_o <= 1'b0;
		end
	end

	// ==========================================================
	// Nibble sequencer
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_d <= 1'b0;
			seq <= '0;
			timer <= '0;
			lat_valid <= 1'b0;
			nibble_o <= '0;
		end else begin
			strobe_d <= strobe_i;
			if (!mouse_mode_o) begin
				seq <= '0;
				timer <= '0;
				lat_valid <= 1'b0;
			end else if (toggle) begin
				seq <= seq + 2'd1;
				timer <= TIMEOUT_BITS'(MOUSE_TIMEOUT);
				case (seq)
					2'd0: begin
						nibble_o <= neg_dx[MOVE_BITS-1 -: NIBBLE_BITS];
						lat_valid <= !q_empty;
					end
					2'd1: nibble_o <= lat_dx[MOVE_BITS-1-NIBBLE_BITS -: NIBBLE_BITS];
					2'd2: nibble_o <= lat_dy[MOVE_BITS-1 -: NIBBLE_BITS];
					default: begin
						nibble_o <= lat_dy[MOVE_BITS-1-NIBBLE_BITS -: NIBBLE_BITS];
						lat_valid <= 1'b0;
					end
				endcase
			end else if (timer != '0) begin
				timer <= timer - 1'b1;
				// Host gave up mid read, start over on the same report
				if (timer == TIMEOUT_BITS'(1))
					seq <= '0;
			end
		end
	end

	// Snapshot of the head report taken on the first nibble
	always_ff @(posedge clk_sys) begin
		if (toggle && (seq == 2'd0)) begin
			lat_dx <= neg_dx;
			lat_dy <= head_dy;
		end
	end

endmodule

/* port_pin_driver.sv */
/*
 * MSX port pin driver
 * Picks joystick or mouse data for each port, applies the strobe
 * to joystick lines and registers the result in MSX pin order
 */
`timescale 1ns/1ps

module port_pin_driver (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic [msx_ctrl_pkg::JOY_BITS-1:0]    joy_i [msx_ctrl_pkg::NUM_PORTS],
	input  logic [msx_ctrl_pkg::BTN_BITS-1:0]    btn_i,
	input  logic [msx_ctrl_pkg::NUM_PORTS-1:0]   mouse_mode_i,
	input  logic [msx_port_pkg::NIBBLE_BITS-1:0] nibble_i [msx_ctrl_pkg::NUM_PORTS],
	input  logic                                 strobe_a_i,
	input  logic                                 strobe_b_i,
	output logic [msx_port_pkg::PIN_BITS-1:0]    pins_a_o,
	output logic [msx_port_pkg::PIN_BITS-1:0]    pins_b_o
);
	import msx_ctrl_pkg::*;
	import msx_port_pkg::*;

	logic [NUM_PORTS-1:0] strobe;
	logic [PIN_BITS-1:0]  pin_next [NUM_PORTS];

	assign strobe = {strobe_b_i, strobe_a_i};

	genvar p;
	generate
		for (p = 0; p < NUM_PORTS; p++) begin : g_port
			logic [JOY_BITS-1:0] pull;
			logic [PIN_BITS-1:0] joy_pins;
			logic [PIN_BITS-1:0] mouse_pins;

			// Lines are only pulled while the strobe is low
			assign pull = strobe[p] ? '0 : joy_i[p];
			assign joy_pins[PIN_UP] = ~pull[JOY_UP];
			assign joy_pins[PIN_DOWN] = ~pull[JOY_DOWN];
			assign joy_pins[PIN_LEFT] = ~pull[JOY_LEFT];
			assign joy_pins[PIN_RIGHT] = ~pull[JOY_RIGHT];
			assign joy_pins[PIN_TRIG_A] = ~pull[JOY_TRIG_A];
			assign joy_pins[PIN_TRIG_B] = ~pull[JOY_TRIG_B];

			assign mouse_pins[PIN_RIGHT] = nibble_i[p][0];
			assign mouse_pins[PIN_LEFT] = nibble_i[p][1];
			assign mouse_pins[PIN_DOWN] = nibble_i[p][2];
			assign mouse_pins[PIN_UP] = nibble_i[p][3];
			assign mouse_pins[PIN_TRIG_A] = ~btn_i[0];
			assign mouse_pins[PIN_TRIG_B] = ~btn_i[1];

			assign pin_next[p] = mouse_mode_i[p] ? mouse_pins : joy_pins;
		end
	endgenerate

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pins_a_o <= '1;
			pins_b_o <= '1;
		end else begin
			pins_a_o <= pin_next[0];
			pins_b_o <= pin_next[1];
		end
	end

endmodule

/* msx_ctrl_top.sv */
/*
 * MSX controller port adapter
 * Host joysticks and mouse reports in, two MSX general purpose
 * ports out. Router, one engine per port and the pin driver.
 */
`timescale 1ns/1ps

module msx_ctrl_top (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic [msx_ctrl_pkg::JOY_BITS-1:0]  joy0_i,
	input  logic [msx_ctrl_pkg::JOY_BITS-1:0]  joy1_i,
	input  logic                               swap_i,
	input  logic [msx_ctrl_pkg::MOVE_BITS-1:0] mouse_dx_i,
	input  logic [msx_ctrl_pkg::MOVE_BITS-1:0] mouse_dy_i,
	input  logic [msx_ctrl_pkg::BTN_BITS-1:0]  mouse_btn_i,
	input  logic                               mouse_strobe_i,
	input  logic [msx_ctrl_pkg::PORT_BITS-1:0] mouse_port_i,
	input  logic                               strobe_a_i,
	input  logic                               strobe_b_i,
	output logic [msx_port_pkg::PIN_BITS-1:0]  pins_a_o,
	output logic [msx_port_pkg::PIN_BITS-1:0]  pins_b_o
);
	import msx_ctrl_pkg::*;
	import msx_port_pkg::*;

	logic [JOY_BITS-1:0]    joy [NUM_PORTS];
	logic [NUM_PORTS-1:0]   rpt_valid;
	logic [MOVE_BITS-1:0]   rpt_dx [NUM_PORTS];
	logic [MOVE_BITS-1:0]   rpt_dy [NUM_PORTS];
	logic [BTN_BITS-1:0]    btn;
	logic [NUM_PORTS-1:0]   credit_ret;
	logic [NUM_PORTS-1:0]   mouse_mode;
	logic [NIBBLE_BITS-1:0] nibble [NUM_PORTS];
	logic [NUM_PORTS-1:0]   strobe;

	// Port A strobe at index 0
	assign strobe = {strobe_b_i, strobe_a_i};

	host_input_router u_router (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.joy0_i         (joy0_i),
		.joy1_i         (joy1_i),
		.swap_i         (swap_i),
		.mouse_dx_i     (mouse_dx_i),
		.mouse_dy_i     (mouse_dy_i),
		.mouse_btn_i    (mouse_btn_i),
		.mouse_strobe_i (mouse_strobe_i),
		.mouse_port_i   (mouse_port_i),
		.credit_ret_i   (credit_ret),
		.joy_o          (joy),
		.rpt_valid_o    (rpt_valid),
		.rpt_dx_o       (rpt_dx),
		.rpt_dy_o       (rpt_dy),
		.btn_o          (btn)
	);

	genvar p;
	generate
		for (p = 0; p < NUM_PORTS; p++) begin : g_engine
			msx_port_engine u_engine (
				.clk_sys      (clk_sys),
				.reset        (reset),
				.joy_i        (joy[p]),
				.strobe_i     (strobe[p]),
				.rpt_valid_i  (rpt_valid[p]),
				.rpt_dx_i     (rpt_dx[p]),
				.rpt_dy_i     (rpt_dy[p]),
				.credit_ret_o (credit_ret[p]),
				.mouse_mode_o (mouse_mode[p]),
				.nibble_o     (nibble[p])
			);
		end
	endgenerate

	port_pin_driver u_driver (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.joy_i        (joy),
		.btn_i        (btn),
		.mouse_mode_i (mouse_mode),
		.nibble_i     (nibble),
		.strobe_a_i   (strobe_a_i),
		.strobe_b_i   (strobe_b_i),
		.pins_a_o     (pins_a_o),
		.pins_b_o     (pins_b_o)
	);

endmodule

/* msx_ctrl_checker.sv */
/*
 * Assertion checker for the MSX controller adapter
 * Router credit bounds, queue room for every report sent, and
 * the pin state right after reset
 */
`timescale 1ns/1ps

module msx_ctrl_checker (
	input logic                                 clk_sys,
	input logic                                 reset,
	input logic [msx_ctrl_pkg::CREDIT_BITS-1:0] credit_a_i,
	input logic [msx_ctrl_pkg::CREDIT_BITS-1:0] credit_b_i,
	input logic [msx_ctrl_pkg::CREDIT_BITS-1:0] q_count_a_i,
	input logic [msx_ctrl_pkg::CREDIT_BITS-1:0] q_count_b_i,
	input logic [msx_ctrl_pkg::NUM_PORTS-1:0]   rpt_valid_i,
	input logic [msx_port_pkg::PIN_BITS-1:0]    pins_a_i,
	input logic [msx_port_pkg::PIN_BITS-1:0]    pins_b_i
);
	import msx_ctrl_pkg::*;

	// ==========================================================
	// Credit rules
	// ==========================================================
	credit_a_bound: assert property (@(posedge clk_sys) disable iff (reset)
		credit_a_i <= CREDIT_BITS'(REPORT_DEPTH))
		else $error("Port A credit count above the report depth");

	credit_b_bound: assert property (@(posedge clk_sys) disable iff (reset)
		credit_b_i <= CREDIT_BITS'(REPORT_DEPTH))
		else $error("Port B credit count above the report depth");

	// Each credit stands for a free slot in the engine queue
	send_a_has_credit: assert property (@(posedge clk_sys) disable iff (reset)
		rpt_valid_i[0] |-> (q_count_a_i < CREDIT_BITS'(REPORT_DEPTH)))
		else $error("Report sent to port A without credit, its queue is full");

	send_b_has_credit: assert property (@(posedge clk_sys) disable iff (reset)
		rpt_valid_i[1] |-> (q_count_b_i < CREDIT_BITS'(REPORT_DEPTH)))
		else $error("Report sent to port B without credit, its queue is full");

	// ==========================================================
	// Reset state
	// ==========================================================
	pins_idle_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> (pins_a_i == '1) && (pins_b_i == '1))
		else $error("Pins not all high after reset release");

endmodule

bind msx_ctrl_top msx_ctrl_checker u_checker (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.credit_a_i  (u_router.g_port[0].credit),
	.credit_b_i  (u_router.g_port[1].credit),
	.q_count_a_i (g_engine[0].u_engine.q_count),
	.q_count_b_i (g_engine[1].u_engine.q_count),
	.rpt_valid_i (rpt_valid),
	.pins_a_i    (pins_a_o),
	.pins_b_i    (pins_b_o)
);

/* tb_msx_ctrl.sv */
/*
 * Testbench for the MSX controller port adapter
 * Joystick and swap paths, mouse nibble reads, credit back-pressure,
 * read timeout and mouse mode exit, checked against a pin model
 */
`timescale 1ns/1ps

module tb_msx_ctrl;
	import msx_ctrl_pkg::*;
	import msx_port_pkg::*;

	// Short tests need a few hundred cycles, the timeout test dominates
	localparam int TEST_CYCLES = MOUSE_TIMEOUT + 10 + 2000;
	localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

	logic                 clk_sys;
	logic                 reset;
	logic [JOY_BITS-1:0]  joy0_i;
	logic [JOY_BITS-1:0]  joy1_i;
	logic                 swap_i;
	logic [MOVE_BITS-1:0] mouse_dx_i;
	logic [MOVE_BITS-1:0] mouse_dy_i;
	logic [BTN_BITS-1:0]  mouse_btn_i;
	logic                 mouse_strobe_i;
	logic [PORT_BITS-1:0] mouse_port_i;
	logic                 strobe_a_i;
	logic                 strobe_b_i;
	logic [PIN_BITS-1:0]  pins_a_o;
	logic [PIN_BITS-1:0]  pins_b_o;
	integer               seed;
	int                   cycles = 0;

	msx_ctrl_top UUT (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.joy0_i         (joy0_i),
		.joy1_i         (joy1_i),
		.swap_i         (swap_i),
		.mouse_dx_i     (mouse_dx_i),
		.mouse_dy_i     (mouse_dy_i),
		.mouse_btn_i    (mouse_btn_i),
		.mouse_strobe_i (mouse_strobe_i),
		.mouse_port_i   (mouse_port_i),
		.strobe_a_i     (strobe_a_i),
		.strobe_b_i     (strobe_b_i),
		.pins_a_o       (pins_a_o),
		.pins_b_o       (pins_b_o)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$fatal(1, "Simulation timeout");
		end
	end

	// ==========================================================
	// Pin model
	// ==========================================================
	function automatic logic [PIN_BITS-1:0] joy_pins(
		input logic [JOY_BITS-1:0] joy,
		input logic                strobe
	);
		logic [PIN_BITS-1:0] pins;
		pins = '1;
		if (!strobe) begin
			pins[PIN_UP] = ~joy[JOY_UP];
			pins[PIN_DOWN] = ~joy[JOY_DOWN];
			pins[PIN_LEFT] = ~joy[JOY_LEFT];
			pins[PIN_RIGHT] = ~joy[JOY_RIGHT];
			pins[PIN_TRIG_A] = ~joy[JOY_TRIG_A];
			pins[PIN_TRIG_B] = ~joy[JOY_TRIG_B];
		end
		return pins;
	endfunction

	function automatic logic [PIN_BITS-1:0] mouse_pins(
		input logic [NIBBLE_BITS-1:0] nib,
		input logic [BTN_BITS-1:0]    btn
	);
		logic [PIN_BITS-1:0] pins;
		pins[PIN_UP] = nib[3];
		pins[PIN_DOWN] = nib[2];
		pins[PIN_LEFT] = nib[1];
		pins[PIN_RIGHT] = nib[0];
		pins[PIN_TRIG_A] = ~btn[0];
		pins[PIN_TRIG_B] = ~btn[1];
		return pins;
	endfunction

	// Nibble k of a report, X sent negated
	function automatic logic [NIBBLE_BITS-1:0] report_nibble(input int dx, input int dy, input int k);
		logic [MOVE_BITS-1:0] neg_dx;
		logic [MOVE_BITS-1:0] dy_bits;
		neg_dx = MOVE_BITS'(-dx);
		dy_bits = MOVE_BITS'(dy);
		case (k)
			0: return neg_dx[8:5];
			1: return neg_dx[4:1];
			2: return dy_bits[8:5];
			default: return dy_bits[4:1];
		endcase
	endfunction

	function automatic int random_move();
		return $random(seed) % 41;
	endfunction

	// ==========================================================
	// Stimulus and checks
	// ==========================================================
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic check_port(
		input string               name,
		input logic [PIN_BITS-1:0] expected,
		input logic [PIN_BITS-1:0] actual
	);
		assert (actual === expected) else begin
			$display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "Pin mismatch in %s", name);
		end
	endtask

	task automatic send_report(input int port, input int dx, input int dy);
		@(negedge clk_sys);
		mouse_port_i = PORT_BITS'(port);
		mouse_dx_i = MOVE_BITS'(dx);
		mouse_dy_i = MOVE_BITS'(dy);
		mouse_strobe_i = 1'b1;
		@(negedge clk_sys);
		mouse_strobe_i = 1'b0;
	endtask

	task automatic toggle_and_check(input string name, input int dx, input int dy, input int k);
		@(negedge clk_sys);
		strobe_a_i = ~strobe_a_i;
		wait_cycles(4);
		check_port($sformatf("%s nibble %0d", name, k),
			mouse_pins(report_nibble(dx, dy, k), mouse_btn_i), pins_a_o);
	endtask

	task automatic read_report(input string name, input int dx, input int dy);
		for (int k = 0; k < 4; k++)
			toggle_and_check(name, dx, dy, k);
	endtask

	initial begin
		int dx [4];
		int dy [4];
		seed = 14;
		reset = 1'b1;
		joy0_i = '0;
		joy1_i = '0;
		swap_i = 1'b0;
		mouse_dx_i = '0;
		mouse_dy_i = '0;
		mouse_btn_i = '0;
		mouse_strobe_i = 1'b0;
		mouse_port_i = '0;
		strobe_a_i = 1'b0;
		strobe_b_i = 1'b0;
		wait_cycles(10);
		reset = 1'b0;

		// Joystick mode, both strobe levels
		for (int i = 0; i < 8; i++) begin
			joy0_i = JOY_BITS'($random(seed));
			joy1_i = JOY_BITS'($random(seed));
			strobe_a_i = 1'b0;
			strobe_b_i = 1'b0;
			wait_cycles(4);
			check_port("joystick A strobe low", joy_pins(joy0_i, 1'b0), pins_a_o);
			check_port("joystick B strobe low", joy_pins(joy1_i, 1'b0), pins_b_o);
			strobe_a_i = 1'b1;
			strobe_b_i = 1'b1;
			wait_cycles(4);
			check_port("joystick A strobe high", joy_pins(joy0_i, 1'b1), pins_a_o);
			check_port("joystick B strobe high", joy_pins(joy1_i, 1'b1), pins_b_o);
		end

		// Swap
		swap_i = 1'b1;
		joy0_i = JOY_BITS'($random(seed));
		joy1_i = JOY_BITS'($random(seed));
		strobe_a_i = 1'b0;
		strobe_b_i = 1'b0;
		wait_cycles(4);
		check_port("swap port A", joy_pins(joy1_i, 1'b0), pins_a_o);
		check_port("swap port B", joy_pins(joy0_i, 1'b0), pins_b_o);
		swap_i = 1'b0;
		joy0_i = '0;
		wait_cycles(4);

		// Single mouse read on port A
		mouse_btn_i = BTN_BITS'($random(seed));
		dx[0] = random_move();
		dy[0] = random_move();
		send_report(0, dx[0], dy[0]);
		wait_cycles(4);
		read_report("mouse read", dx[0], dy[0]);

		// Four reports against two credits, the last two merge
		for (int i = 0; i < 4; i++) begin
			dx[i] = random_move();
			dy[i] = random_move();
			send_report(0, dx[i], dy[i]);
		end
		wait_cycles(4);
		read_report("credit report 1", dx[0], dy[0]);
		read_report("credit report 2", dx[1], dy[1]);
		read_report("credit merged 3 and 4", dx[2] + dx[3], dy[2] + dy[3]);

		// Abandoned read restarts on the same report
		dx[0] = random_move();
		dy[0] = random_move();
		send_report(0, dx[0], dy[0]);
		wait_cycles(4);
		toggle_and_check("timeout before", dx[0], dy[0], 0);
		toggle_and_check("timeout before", dx[0], dy[0], 1);
		wait_cycles(MOUSE_TIMEOUT + 10);
		read_report("timeout restart", dx[0], dy[0]);

		// Joystick press leaves mouse mode and frees the queue
		for (int i = 0; i < 2; i++) begin
			dx[i] = random_move();
			dy[i] = random_move();
			send_report(0, dx[i], dy[i]);
		end
		wait_cycles(4);
		joy0_i = JOY_BITS'($random(seed)) | JOY_BITS'(1);
		wait_cycles(4);
		strobe_a_i = 1'b0;
		wait_cycles(4);
		check_port("mode exit joystick", joy_pins(joy0_i, 1'b0), pins_a_o);
		joy0_i = '0;
		wait_cycles(4);
		dx[2] = random_move();
		dy[2] = random_move();
		send_report(0, dx[2], dy[2]);
		wait_cycles(4);
		read_report("mode exit new report", dx[2], dy[2]);

		$display("Finished with no errors");
		$finish;
	end

endmodule

/* filelist.f */
msx_ctrl_pkg.sv
msx_port_pkg.sv
host_input_router.sv
msx_port_engine.sv
port_pin_driver.sv
msx_ctrl_top.sv
msx_ctrl_checker.sv
tb_msx_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MSX controller adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module tb_msx_ctrl \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
